//--- bench/step_curve_properties.sv
module step_curve_properties (
  input logic                   clk,
  input logic                   reset_gen,
  input step_curve_pkg::phase_t phase,
  input logic                   sphi1,
  input logic                   sphi2,
  input logic                   frame_done
);

  // both sample clocks are driven as one burst.
  sphi_pair_match: assert property (@(posedge clk) disable iff (reset_gen)
    sphi1 == sphi2)
    else $error("sphi1 and sphi2 differ");

  frame_done_single: assert property (@(posedge clk) disable iff (reset_gen)
    !(frame_done && $past(frame_done)))
    else $error("frame_done stayed high for two cycles");

  frame_done_in_settle: assert property (@(posedge clk) disable iff (reset_gen)
    frame_done |-> phase == step_curve_pkg::PH_SETTLE)
    else $error("frame_done raised outside the settle phase");

endmodule

bind frame_sequencer step_curve_properties step_curve_properties_inst (
  .clk        (clk),
  .reset_gen  (reset_gen),
  .phase      (phase),
  .sphi1      (sphi1),
  .sphi2      (sphi2),
  .frame_done (frame_done)
);

//--- bench/step_curve_tb.sv
module step_curve_tb;

  localparam int ROWS      = 4;
  localparam int SETTLE    = 20;
  localparam int WRITE_POS = 30; // queued writes start at this cycle of their frame.
  localparam int MAX_ITEMS = 32;

  logic        clk = 1'b0;
  logic        reset_gen;
  logic        cfg_wr;
  logic [2:0]  cfg_addr;
  logic [15:0] cfg_data;
  logic        cal, le, pix_reset, rbi, rphi1, rphi2, sphi1, sphi2;
  logic        cs, sbi, seb, r12, is1, is2, sr;
  logic [15:0] aref, rg, vana, vthr;
  logic        frame_done;

  // trace contents.
  logic [2:0]  wr_addr [MAX_ITEMS];
  logic [15:0] wr_data [MAX_ITEMS];
  int          wr_frame [MAX_ITEMS];
  int          frame_cal [MAX_ITEMS];
  logic [15:0] frame_vthr [MAX_ITEMS];
  int          wr_count, frame_count, wr_next;

  // reference model of the chip outputs.
  step_curve_pkg::phase_t ph;
  int          k, row, pos, frame_idx;
  logic        m_cal, m_le, m_pixr, m_rbi, m_rphi1, m_rphi2, m_sphi;
  logic [15:0] m_aref, m_vana, m_rg;
  logic [6:0]  m_pins;
  logic        pend_wr, ramp_touched, running;
  logic [2:0]  pend_addr;
  logic [15:0] pend_data;

  int error_count, check_count, cycle_limit;
  int cycle_count = 0;

  step_curve_top #(
    .ROW_COUNT     (ROWS),
    .SETTLE_CYCLES (SETTLE)
  ) step_curve_top_inst (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, the trace never finished", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic int inject_cycles(input int f);
    if (frame_cal[f] == 0) return 1; // a zero count still injects once.
    return frame_cal[f];
  endfunction

  task automatic check_bit(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail %0t %s expected %b got %b", $time, name, expected, actual);
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic read_trace();
    int               fd;
    int               n;
    int               c;
    logic [7:0]       tag;
    logic [8*128-1:0] rest;
    logic [15:0]      a;
    logic [15:0]      d;
    fd = $fopen("bench/step_curve_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file bench/step_curve_trace.txt");
      error_count++;
    end else begin
      n = $fscanf(fd, "%s", tag);
      while (n == 1) begin
        if (tag == "#") begin
          n = $fgets(rest, fd);
        end else if (tag == "w") begin
          n = $fscanf(fd, "%h %h", a, d);
          wr_frame[wr_count] = frame_count; // belongs to the next frame line.
          wr_addr[wr_count] = a[2:0];
          wr_data[wr_count] = d;
          wr_count++;
        end else if (tag == "f") begin
          n = $fscanf(fd, "%d %h", c, d);
          frame_cal[frame_count] = c;
          frame_vthr[frame_count] = d;
          frame_count++;
        end else begin
          $display("the trace file holds a line of unknown kind");
          error_count++;
        end
        n = $fscanf(fd, "%s", tag);
      end
      $fclose(fd);
    end
  endtask

  // applies the table entry of the cycle that ends at this edge.
  task automatic advance_model();
    logic last;
    last = 1'b0;
    case (ph)
      step_curve_pkg::PH_PREPARE: begin
        if (k == 0) begin
          m_cal = 1'b1;
          m_sphi = 1'b0;
          m_pixr = 1'b0;
          m_rbi = 1'b1;
          m_rphi1 = 1'b1;
          m_rphi2 = 1'b1;
          m_le = 1'b1;
        end
        if (k == 2) m_sphi = 1'b1;
        if (k == 5) m_sphi = 1'b0;
        last = (k == 9);
      end
      step_curve_pkg::PH_INJECT: begin
        if (k == 0) m_cal = 1'b0;
        last = (k == inject_cycles(frame_idx) - 1);
      end
      step_curve_pkg::PH_PIX_RESET: begin
        if (k == 0) m_le = 1'b0;
        if (k == 2) m_pixr = 1'b1;
        if (k == 4 || k == 13) m_rbi = 1'b0;
        if (k == 8) begin
          m_rphi1 = 1'b0;
          m_rphi2 = 1'b0;
        end
        if (k == 11) begin
          m_rbi = 1'b1;
          m_rphi1 = 1'b1;
        end
        if (k == 12) m_rphi1 = 1'b0;
        last = (k == 13);
      end
      step_curve_pkg::PH_READOUT: begin
        if (k == 0) begin
          m_cal = 1'b0;
          m_pixr = 1'b1;
          m_rbi = 1'b0;
          m_rphi1 = 1'b0;
          m_rphi2 = 1'b1;
          m_le = 1'b1;
        end
        if (k == 21) m_rphi2 = 1'b0;
        if (k == 22) m_rphi1 = 1'b1;
        if (k == 23) m_rphi1 = 1'b0;
        last = (k == 23) && (row == ROWS - 1);
      end
      default: begin
        if (k == 0) begin
          m_cal = 1'b1;
          m_pixr = 1'b1;
          m_rbi = 1'b0;
          m_rphi1 = 1'b0;
          m_rphi2 = 1'b0;
          m_sphi = 1'b0;
          m_le = 1'b1;
        end
        last = (k == SETTLE - 1);
      end
    endcase
    pos++;
    if (last) begin
      k = 0;
      row = 0;
      case (ph)
        step_curve_pkg::PH_PREPARE:   ph = step_curve_pkg::PH_INJECT;
        step_curve_pkg::PH_INJECT:    ph = step_curve_pkg::PH_PIX_RESET;
        step_curve_pkg::PH_PIX_RESET: ph = step_curve_pkg::PH_READOUT;
        step_curve_pkg::PH_READOUT:   ph = step_curve_pkg::PH_SETTLE;
        default: begin
          ph = step_curve_pkg::PH_PREPARE;
          frame_idx++;
          pos = 0;
          ramp_touched = 1'b0;
        end
      endcase
    end else if (ph == step_curve_pkg::PH_READOUT && k == 23) begin
      k = 0;
      row++;
    end else begin
      k++;
    end
  endtask

  task automatic drive_inputs();
    if (pend_wr) begin
      case (pend_addr) // the strobe of the cycle just ended lands at this edge.
        step_curve_pkg::REG_AREF: m_aref = pend_data;
        step_curve_pkg::REG_VANA: m_vana = pend_data;
        step_curve_pkg::REG_RG:   m_rg = pend_data;
        step_curve_pkg::REG_PINS: m_pins = pend_data[6:0];
        default: ;
      endcase
    end
    pend_wr = 1'b0;
    if (wr_next < wr_count && wr_frame[wr_next] == frame_idx && pos >= WRITE_POS) begin
      pend_wr = 1'b1;
      pend_addr = wr_addr[wr_next];
      pend_data = wr_data[wr_next];
      if (pend_addr == step_curve_pkg::REG_VTHR_START || pend_addr == step_curve_pkg::REG_VTHR_STEP
          || pend_addr == step_curve_pkg::REG_VTHR_POINTS) ramp_touched = 1'b1;
      wr_next++;
    end
    cfg_wr <= pend_wr;
    cfg_addr <= pend_addr;
    cfg_data <= pend_data;
  endtask

  task automatic check_cycle();
    check_bit("cal", m_cal, cal);
    check_bit("le", m_le, le);
    check_bit("pix_reset", m_pixr, pix_reset);
    check_bit("rbi", m_rbi, rbi);
    check_bit("rphi1", m_rphi1, rphi1);
    check_bit("rphi2", m_rphi2, rphi2);
    check_bit("sphi1", m_sphi, sphi1);
    check_bit("sphi2", m_sphi, sphi2);
    check_bit("frame_done", ph == step_curve_pkg::PH_SETTLE && k == SETTLE - 1, frame_done);
    check_word("aref", m_aref, aref);
    check_word("vana", m_vana, vana);
    check_word("rg", m_rg, rg);
    check_bit("cs", m_pins[step_curve_pkg::PIN_CS], cs);
    check_bit("sbi", m_pins[step_curve_pkg::PIN_SBI], sbi);
    check_bit("seb", m_pins[step_curve_pkg::PIN_SEB], seb);
    check_bit("r12", m_pins[step_curve_pkg::PIN_R12], r12);
    check_bit("is1", m_pins[step_curve_pkg::PIN_IS1], is1);
    check_bit("is2", m_pins[step_curve_pkg::PIN_IS2], is2);
    check_bit("sr", m_pins[step_curve_pkg::PIN_SR], sr);
    // a ramp write moves vthr inside its frame, so only the first cycle is checked then.
    if (running && frame_idx < frame_count && (pos == 0 || !ramp_touched)) begin
      check_word("vthr", frame_vthr[frame_idx], vthr);
    end
  endtask

  initial begin
    reset_gen = 1'b1;
    cfg_wr = 1'b0;
    cfg_addr = 3'd0;
    cfg_data = 16'h0000;
    error_count = 0;
    check_count = 0;
    wr_count = 0;
    frame_count = 0;
    wr_next = 0;
    ph = step_curve_pkg::PH_PREPARE;
    k = 0;
    row = 0;
    pos = 0;
    frame_idx = 0;
    {m_cal, m_le, m_pixr, m_rbi, m_rphi1, m_rphi2, m_sphi} = 7'b0;
    m_aref = 16'h0033;
    m_vana = 16'h0066;
    m_rg = 16'h0033;
    m_pins = 7'b1010100; // seb, is1 and sr high.
    pend_wr = 1'b0;
    pend_addr = 3'd0;
    pend_data = 16'h0000;
    ramp_touched = 1'b0;
    running = 1'b0;
    read_trace();
    cycle_limit = 10 + 200;
    for (int f = 0; f < frame_count; f++) begin
      cycle_limit += 10 + inject_cycles(f) + 14 + 24 * ROWS + SETTLE;
    end
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      if (i == 9) begin
        reset_gen <= 1'b0;
        running = 1'b1;
      end
      @(negedge clk);
      check_cycle();
    end
    while (frame_idx < frame_count) begin
      @(posedge clk);
      advance_model();
      drive_inputs();
      @(negedge clk);
      check_cycle();
    end
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- bench/step_curve_trace.txt
# w addr data       register write issued during the frame of the next f line
# f cal_count vthr  expected inject length and threshold code of one frame
w 0 0005
w 1 0020
w 2 0003
f 1 0025
w 3 0004
f 5 0020
w 4 1234
w 5 0abc
w 6 0f0f
w 7 00ab
f 5 0023
w 0 0000
f 5 0026
w 0 0002
w 7 0054
f 1 0029
w 4 0033
f 2 0020

//--- project.f
src/step_curve_pkg.sv
src/seq_config_regs.sv
src/frame_sequencer.sv
src/threshold_stepper.sv
src/step_curve_top.sv
bench/step_curve_properties.sv
bench/step_curve_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the step curve testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module step_curve_tb -f project.f \
  -o step_curve_sim > sim.log 2>&1 \
  && ./obj_dir/step_curve_sim >> sim.log 2>&1
grep -q "=== PASS ===" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- src/frame_sequencer.sv
module frame_sequencer #(
  parameter int ROW_COUNT     = 127,
  parameter int SETTLE_CYCLES = 300
) (
  input  logic        clk,
  input  logic        reset_gen,
  input  logic [15:0] cal_count,
  output logic        cal,
  output logic        le,
  output logic        pix_reset,
  output logic        rbi,
  output logic        rphi1,
  output logic        rphi2,
  output logic        sphi1,
  output logic        sphi2,
  output logic        frame_done
);

  step_curve_pkg::phase_t phase;
  step_curve_pkg::phase_t next_phase;
  logic [4:0]  offset;     // cycle offset k inside prepare, pix_reset and a readout row.
  logic [15:0] iter;       // inject cycles, readout rows or settle cycles.
  logic [15:0] cal_len;
  logic        phase_last;

  always_comb begin
    case (phase)
      step_curve_pkg::PH_PREPARE: begin
        phase_last = (offset == 5'd9);
        next_phase = step_curve_pkg::PH_INJECT;
      end
      step_curve_pkg::PH_INJECT: begin
        phase_last = (iter == cal_len - 16'd1);
        next_phase = step_curve_pkg::PH_PIX_RESET;
      end
      step_curve_pkg::PH_PIX_RESET: begin
        phase_last = (offset == 5'd13);
        next_phase = step_curve_pkg::PH_READOUT;
      end
      step_curve_pkg::PH_READOUT: begin
        phase_last = (offset == 5'd23) && (iter == 16'(ROW_COUNT - 1));
        next_phase = step_curve_pkg::PH_SETTLE;
      end
      default: begin
        phase_last = (iter == 16'(SETTLE_CYCLES - 1));
        next_phase = step_curve_pkg::PH_PREPARE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_gen) begin
      phase   <= step_curve_pkg::PH_PREPARE;
      offset  <= 5'd0;
      iter    <= 16'd0;
      cal_len <= 16'd1;
    end else begin
      // a new inject length only takes hold at the start of a frame.
      if (phase == step_curve_pkg::PH_PREPARE && offset == 5'd0) begin
        cal_len <= (cal_count == 16'd0) ? 16'd1 : cal_count;
      end
      if (phase_last) begin
        phase  <= next_phase;
        offset <= 5'd0;
        iter   <= 16'd0;
      end else if (phase == step_curve_pkg::PH_INJECT || phase == step_curve_pkg::PH_SETTLE) begin
        iter <= iter + 16'd1;
      end else if (phase == step_curve_pkg::PH_READOUT && offset == 5'd23) begin
        offset <= 5'd0;
        iter   <= iter + 16'd1;
      end else begin
        offset <= offset + 5'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_gen) begin
      cal       <= 1'b0;
      le        <= 1'b0;
      pix_reset <= 1'b0;
      rbi       <= 1'b0;
      rphi1     <= 1'b0;
      rphi2     <= 1'b0;
      sphi1     <= 1'b0;
      sphi2     <= 1'b0;
    end else begin
      case (phase)
        step_curve_pkg::PH_PREPARE: begin
          if (offset == 5'd0) begin
            cal       <= 1'b1;
            pix_reset <= 1'b0;
            rbi       <= 1'b1;
            rphi1     <= 1'b1;
            rphi2     <= 1'b1;
            le        <= 1'b1;
          end
          if (offset == 5'd2) begin
            sphi1 <= 1'b1; // short sample-clock burst.
            sphi2 <= 1'b1;
          end
          if (offset == 5'd5 || offset == 5'd0) begin
            sphi1 <= 1'b0;
            sphi2 <= 1'b0;
          end
        end
        step_curve_pkg::PH_INJECT: begin
          cal <= 1'b0;
        end
        step_curve_pkg::PH_PIX_RESET: begin
          if (offset == 5'd0) le <= 1'b0;
          if (offset == 5'd2) pix_reset <= 1'b1;
          if (offset == 5'd4 || offset == 5'd13) rbi <= 1'b0;
          if (offset == 5'd8) begin
            rphi1 <= 1'b0;
            rphi2 <= 1'b0;
          end
          if (offset == 5'd11) begin
            rbi   <= 1'b1;
            rphi1 <= 1'b1;
          end
          if (offset == 5'd12) rphi1 <= 1'b0;
        end
        step_curve_pkg::PH_READOUT: begin
          if (offset == 5'd0) begin
            le    <= 1'b1;
            rphi2 <= 1'b1;
          end
          if (offset == 5'd21) rphi2 <= 1'b0;
          if (offset == 5'd22) rphi1 <= 1'b1;
          if (offset == 5'd23) rphi1 <= 1'b0;
        end
        default: begin
          cal   <= 1'b1; // array stays in reset while the pulse recovers.
          rphi2 <= 1'b0;
        end
      endcase
    end
  end

  assign frame_done = (phase == step_curve_pkg::PH_SETTLE) && phase_last;

endmodule

//--- src/seq_config_regs.sv
module seq_config_regs (
  input  logic                              clk,
  input  logic                              reset_gen,
  input  logic                              cfg_wr,
  input  logic [step_curve_pkg::ADDR_W-1:0] cfg_addr,
  input  logic [step_curve_pkg::DAC_W-1:0]  cfg_data,
  output logic [15:0]                       cal_count,
  output logic [step_curve_pkg::DAC_W-1:0]  vthr_start,
  output logic [step_curve_pkg::DAC_W-1:0]  vthr_step,
  output logic [15:0]                       vthr_points,
  output logic [step_curve_pkg::DAC_W-1:0]  aref,
  output logic [step_curve_pkg::DAC_W-1:0]  vana,
  output logic [step_curve_pkg::DAC_W-1:0]  rg,
  output logic                              cs,
  output logic                              sbi,
  output logic                              seb,
  output logic                              r12,
  output logic                              is1,
  output logic                              is2,
  output logic                              sr
);

  // seb, is1 and sr come up high, as on the bench setup.
  localparam logic [step_curve_pkg::PINS_W-1:0] PINS_RESET =
    (step_curve_pkg::PINS_W'(1) << step_curve_pkg::PIN_SEB) |
    (step_curve_pkg::PINS_W'(1) << step_curve_pkg::PIN_IS1) |
    (step_curve_pkg::PINS_W'(1) << step_curve_pkg::PIN_SR);

  logic [step_curve_pkg::PINS_W-1:0] pins;

  always_ff @(posedge clk) begin
    if (reset_gen) begin
      cal_count   <= 16'd1;
      vthr_start  <= 16'h0025;
      vthr_step   <= 16'h0000;
      vthr_points <= 16'd1;
      aref        <= 16'h0033;
      vana        <= 16'h0066;
      rg          <= 16'h0033;
      pins        <= PINS_RESET;
    end else if (cfg_wr) begin
      case (cfg_addr)
        step_curve_pkg::REG_CAL_COUNT:   cal_count <= cfg_data;
        step_curve_pkg::REG_VTHR_START:  vthr_start <= cfg_data;
        step_curve_pkg::REG_VTHR_STEP:   vthr_step <= cfg_data;
        step_curve_pkg::REG_VTHR_POINTS: vthr_points <= cfg_data;
        step_curve_pkg::REG_AREF:        aref <= cfg_data;
        step_curve_pkg::REG_VANA:        vana <= cfg_data;
        step_curve_pkg::REG_RG:          rg <= cfg_data;
        step_curve_pkg::REG_PINS:        pins <= cfg_data[step_curve_pkg::PINS_W-1:0];
        default: ; // nothing else is mapped.
      endcase
    end
  end

  assign cs  = pins[step_curve_pkg::PIN_CS];
  assign sbi = pins[step_curve_pkg::PIN_SBI];
  assign seb = pins[step_curve_pkg::PIN_SEB];
  assign r12 = pins[step_curve_pkg::PIN_R12];
  assign is1 = pins[step_curve_pkg::PIN_IS1];
  assign is2 = pins[step_curve_pkg::PIN_IS2];
  assign sr  = pins[step_curve_pkg::PIN_SR];

endmodule

//--- src/step_curve_pkg.sv
package step_curve_pkg;

  localparam int DAC_W = 16;
  localparam int ADDR_W = 3;

  // frame phases in the order the sequencer walks them.
  typedef enum logic [2:0] {
    PH_PREPARE   = 3'd0,
    PH_INJECT    = 3'd1,
    PH_PIX_RESET = 3'd2,
    PH_READOUT   = 3'd3,
    PH_SETTLE    = 3'd4
  } phase_t;

  localparam logic [ADDR_W-1:0] REG_CAL_COUNT   = 3'd0;
  localparam logic [ADDR_W-1:0] REG_VTHR_START  = 3'd1;
  localparam logic [ADDR_W-1:0] REG_VTHR_STEP   = 3'd2;
  localparam logic [ADDR_W-1:0] REG_VTHR_POINTS = 3'd3;
  localparam logic [ADDR_W-1:0] REG_AREF        = 3'd4;
  localparam logic [ADDR_W-1:0] REG_VANA        = 3'd5;
  localparam logic [ADDR_W-1:0] REG_RG          = 3'd6;
  localparam logic [ADDR_W-1:0] REG_PINS        = 3'd7;

  // bit positions of the static chip pins inside REG_PINS.
  localparam int PINS_W  = 7;
  localparam int PIN_CS  = 0;
  localparam int PIN_SBI = 1;
  localparam int PIN_SEB = 2;
  localparam int PIN_R12 = 3;
  localparam int PIN_IS1 = 4;
  localparam int PIN_IS2 = 5;
  localparam int PIN_SR  = 6;

endpackage

//--- src/step_curve_top.sv
module step_curve_top #(
  parameter int ROW_COUNT     = 127,
  parameter int SETTLE_CYCLES = 300
) (
  input  logic                              clk,
  input  logic                              reset_gen,
  input  logic                              cfg_wr,
  input  logic [step_curve_pkg::ADDR_W-1:0] cfg_addr,
  input  logic [step_curve_pkg::DAC_W-1:0]  cfg_data,
  output logic                              cal,
  output logic                              le,
  output logic                              pix_reset,
  output logic                              rbi,
  output logic                              rphi1,
  output logic                              rphi2,
  output logic                              sphi1,
  output logic                              sphi2,
  output logic                              cs,
  output logic                              sbi,
  output logic                              seb,
  output logic                              r12,
  output logic                              is1,
  output logic                              is2,
  output logic                              sr,
  output logic [step_curve_pkg::DAC_W-1:0]  aref,
  output logic [step_curve_pkg::DAC_W-1:0]  rg,
  output logic [step_curve_pkg::DAC_W-1:0]  vana,
  output logic [step_curve_pkg::DAC_W-1:0]  vthr,
  output logic                              frame_done
);

  logic [15:0]                      cal_count;
  logic [step_curve_pkg::DAC_W-1:0] vthr_start;
  logic [step_curve_pkg::DAC_W-1:0] vthr_step;
  logic [15:0]                      vthr_points;

  seq_config_regs seq_config_regs_inst (
    .clk         (clk),
    .reset_gen   (reset_gen),
    .cfg_wr      (cfg_wr),
    .cfg_addr    (cfg_addr),
    .cfg_data    (cfg_data),
    .cal_count   (cal_count),
    .vthr_start  (vthr_start),
    .vthr_step   (vthr_step),
    .vthr_points (vthr_points),
    .aref        (aref),
    .vana        (vana),
    .rg          (rg),
    .cs          (cs),
    .sbi         (sbi),
    .seb         (seb),
    .r12         (r12),
    .is1         (is1),
    .is2         (is2),
    .sr          (sr)
  );

  frame_sequencer #(
    .ROW_COUNT     (ROW_COUNT),
    .SETTLE_CYCLES (SETTLE_CYCLES)
  ) frame_sequencer_inst (
    .clk        (clk),
    .reset_gen  (reset_gen),
    .cal_count  (cal_count),
    .cal        (cal),
    .le         (le),
    .pix_reset  (pix_reset),
    .rbi        (rbi),
    .rphi1      (rphi1),
    .rphi2      (rphi2),
    .sphi1      (sphi1),
    .sphi2      (sphi2),
    .frame_done (frame_done)
  );

  threshold_stepper threshold_stepper_inst (
    .clk         (clk),
    .reset_gen   (reset_gen),
    .frame_done  (frame_done),
    .vthr_start  (vthr_start),
    .vthr_step   (vthr_step),
    .vthr_points (vthr_points),
    .vthr        (vthr)
  );

endmodule

//--- src/threshold_stepper.sv
module threshold_stepper (
  input  logic                             clk,
  input  logic                             reset_gen,
  input  logic                             frame_done,
  input  logic [step_curve_pkg::DAC_W-1:0] vthr_start,
  input  logic [step_curve_pkg::DAC_W-1:0] vthr_step,
  input  logic [15:0]                      vthr_points,
  output logic [step_curve_pkg::DAC_W-1:0] vthr
);

  logic [15:0] point_idx;
  logic [15:0] idx_next;
  logic [15:0] last_idx;
  logic [step_curve_pkg::DAC_W-1:0] ramp_offset;

  // zero points behaves like a single point.
  assign last_idx = (vthr_points == 16'd0) ? 16'd0 : vthr_points - 16'd1;

  always_comb begin
    idx_next = point_idx;
    if (frame_done) begin
      // >= also catches a point count shrunk below the current index.
      idx_next = (point_idx >= last_idx) ? 16'd0 : point_idx + 16'd1;
    end
  end

  assign ramp_offset = vthr_step * idx_next;

  always_ff @(posedge clk) begin
    if (reset_gen) begin
      point_idx <= 16'd0;
    end else begin
      point_idx <= idx_next;
    end
  end

  // built from the next index so the new code shows right after frame_done.
  always_ff @(posedge clk) begin
    vthr <= vthr_start + ramp_offset;
  end

endmodule
